// File: common/mips_pkg.sv
package mips_pkg;

  // fetch address after reset
  localparam logic [31:0] reset_vector = 32'hbfc0_0000;

  // primary opcodes
  localparam logic [5:0] op_special = 6'h00;
  localparam logic [5:0] op_j       = 6'h02;
  localparam logic [5:0] op_jal     = 6'h03;
  localparam logic [5:0] op_beq     = 6'h04;
  localparam logic [5:0] op_bne     = 6'h05;
  localparam logic [5:0] op_addiu   = 6'h09;
  localparam logic [5:0] op_slti    = 6'h0a;
  localparam logic [5:0] op_andi    = 6'h0c;
  localparam logic [5:0] op_ori     = 6'h0d;
  localparam logic [5:0] op_xori    = 6'h0e;
  localparam logic [5:0] op_lui     = 6'h0f;
  localparam logic [5:0] op_lw      = 6'h23;
  localparam logic [5:0] op_sw      = 6'h2b;

  // function codes under op_special
  localparam logic [5:0] fn_sll   = 6'h00;
  localparam logic [5:0] fn_srl   = 6'h02;
  localparam logic [5:0] fn_sra   = 6'h03;
  localparam logic [5:0] fn_jr    = 6'h08;
  localparam logic [5:0] fn_mfhi  = 6'h10;
  localparam logic [5:0] fn_mthi  = 6'h11;
  localparam logic [5:0] fn_mflo  = 6'h12;
  localparam logic [5:0] fn_mtlo  = 6'h13;
  localparam logic [5:0] fn_multu = 6'h19;
  localparam logic [5:0] fn_addu  = 6'h21;
  localparam logic [5:0] fn_subu  = 6'h23;
  localparam logic [5:0] fn_and   = 6'h24;
  localparam logic [5:0] fn_or    = 6'h25;
  localparam logic [5:0] fn_xor   = 6'h26;
  localparam logic [5:0] fn_slt   = 6'h2a;
  localparam logic [5:0] fn_sltu  = 6'h2b;

  // alu operations
  localparam logic [3:0] alu_add  = 4'd0;
  localparam logic [3:0] alu_sub  = 4'd1;
  localparam logic [3:0] alu_and  = 4'd2;
  localparam logic [3:0] alu_or   = 4'd3;
  localparam logic [3:0] alu_xor  = 4'd4;
  localparam logic [3:0] alu_nor  = 4'd5;
  localparam logic [3:0] alu_slt  = 4'd6;
  localparam logic [3:0] alu_sltu = 4'd7;
  localparam logic [3:0] alu_sll  = 4'd8;
  localparam logic [3:0] alu_srl  = 4'd9;
  localparam logic [3:0] alu_sra  = 4'd10;
  localparam logic [3:0] alu_lui  = 4'd11;

  // one instruction word, three encodings
  typedef union packed {
    struct packed {
      logic [5:0] op;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [4:0] shamt;
      logic [5:0] funct;
    } r;
    struct packed {
      logic [5:0]  op;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm;
    } i;
    struct packed {
      logic [5:0]  op;
      logic [25:0] target;
    } j;
  } instr_t;

endpackage

// File: source/register_file.sv
`timescale 1ns/1ps

module register_file import mips_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic [4:0]  rs_addr,
  input  logic [4:0]  rt_addr,
  input  logic [4:0]  rd_addr,
  input  logic [31:0] rd_data,
  input  logic        write,
  output logic [31:0] rs_data,
  output logic [31:0] rt_data,
  output logic [31:0] register_v0
);

  logic [31:0] regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int n = 0; n < 32; n++) begin
        regs[n] <= 32'h0000_0000;
      end
    end else if (write && rd_addr != 5'd0) begin
      // r0 keeps its reset value of zero
      regs[rd_addr] <= rd_data;
    end
  end

  // combinational reads
  assign rs_data = regs[rs_addr];
  assign rt_data = regs[rt_addr];

  // v0 is r2
  assign register_v0 = regs[2];

endmodule

// File: source/pc_unit.sv
`timescale 1ns/1ps

module pc_unit import mips_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        clk_enable,
  input  instr_t      instr,
  input  logic [31:0] rs_data,
  input  logic        branch,
  input  logic        branch_ne,
  input  logic        equal,
  input  logic        jump,
  input  logic        jump_reg,
  output logic [31:0] instr_address,
  output logic [31:0] pc_plus4,
  output logic        active,
  output logic        step
);

  logic [31:0] pc;
  logic [31:0] branch_target;
  logic [31:0] jump_target;
  logic [31:0] next_pc;
  logic        branch_taken;

  // one instruction retires on each edge where this is high
  assign step = clk_enable & active & ~reset;

  assign pc_plus4      = pc + 32'd4;
  assign branch_target = pc_plus4 + {{14{instr.i.imm[15]}}, instr.i.imm, 2'b00};
  assign jump_target   = {pc_plus4[31:28], instr.j.target, 2'b00};

  // bne inverts the sense of the compare
  assign branch_taken = branch & (equal ^ branch_ne);

  always_comb begin
    if (jump_reg)
      next_pc = rs_data;
    else if (jump)
      next_pc = jump_target;
    else if (branch_taken)
      next_pc = branch_target;
    else
      next_pc = pc_plus4;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc     <= reset_vector;
      active <= 1'b1;
    end else if (step) begin
      pc <= next_pc;
      // landing on address zero halts the core
      if (next_pc == 32'h0000_0000)
        active <= 1'b0;
    end
  end

  assign instr_address = pc;

endmodule

// File: source/control.sv
`timescale 1ns/1ps

module control import mips_pkg::*; (
  input  instr_t     instr,
  input  logic       step,
  output logic [3:0] alu_op,
  output logic       alu_src,
  output logic       imm_zero,
  output logic       dest_rd,
  output logic       link,
  output logic       reg_write,
  output logic       mem_to_reg,
  output logic       hi_to_reg,
  output logic       lo_to_reg,
  output logic       hi_write,
  output logic       lo_write,
  output logic       mult_start,
  output logic       branch,
  output logic       branch_ne,
  output logic       jump,
  output logic       jump_reg,
  output logic       data_read,
  output logic       data_write
);

  // ungated enables, qualified by step below
  logic wr_reg, wr_hi, wr_lo, mult, rd_mem, wr_mem;

  always_comb begin
    alu_op     = alu_add;
    alu_src    = 1'b0;
    imm_zero   = 1'b0;
    dest_rd    = 1'b0;
    link       = 1'b0;
    mem_to_reg = 1'b0;
    hi_to_reg  = 1'b0;
    lo_to_reg  = 1'b0;
    branch     = 1'b0;
    branch_ne  = 1'b0;
    jump       = 1'b0;
    jump_reg   = 1'b0;
    wr_reg     = 1'b0;
    wr_hi      = 1'b0;
    wr_lo      = 1'b0;
    mult       = 1'b0;
    rd_mem     = 1'b0;
    wr_mem     = 1'b0;
    case (instr.r.op)
      op_special: begin
        dest_rd = 1'b1;
        case (instr.r.funct)
          fn_addu:  begin alu_op = alu_add;  wr_reg = 1'b1; end
          fn_subu:  begin alu_op = alu_sub;  wr_reg = 1'b1; end
          fn_and:   begin alu_op = alu_and;  wr_reg = 1'b1; end
          fn_or:    begin alu_op = alu_or;   wr_reg = 1'b1; end
          fn_xor:   begin alu_op = alu_xor;  wr_reg = 1'b1; end
          fn_slt:   begin alu_op = alu_slt;  wr_reg = 1'b1; end
          fn_sltu:  begin alu_op = alu_sltu; wr_reg = 1'b1; end
          fn_sll:   begin alu_op = alu_sll;  wr_reg = 1'b1; end
          fn_srl:   begin alu_op = alu_srl;  wr_reg = 1'b1; end
          fn_sra:   begin alu_op = alu_sra;  wr_reg = 1'b1; end
          fn_jr:    jump_reg = 1'b1;
          fn_multu: mult = 1'b1;
          fn_mfhi:  begin hi_to_reg = 1'b1; wr_reg = 1'b1; end
          fn_mflo:  begin lo_to_reg = 1'b1; wr_reg = 1'b1; end
          fn_mthi:  wr_hi = 1'b1;
          fn_mtlo:  wr_lo = 1'b1;
          default:  dest_rd = 1'b0;
        endcase
      end
      op_addiu: begin alu_src = 1'b1; wr_reg = 1'b1; end
      op_slti:  begin alu_op = alu_slt; alu_src = 1'b1; wr_reg = 1'b1; end
      op_andi:  begin alu_op = alu_and; alu_src = 1'b1; imm_zero = 1'b1; wr_reg = 1'b1; end
      op_ori:   begin alu_op = alu_or;  alu_src = 1'b1; imm_zero = 1'b1; wr_reg = 1'b1; end
      op_xori:  begin alu_op = alu_xor; alu_src = 1'b1; imm_zero = 1'b1; wr_reg = 1'b1; end
      op_lui:   begin alu_op = alu_lui; alu_src = 1'b1; imm_zero = 1'b1; wr_reg = 1'b1; end
      op_lw:    begin alu_src = 1'b1; mem_to_reg = 1'b1; rd_mem = 1'b1; wr_reg = 1'b1; end
      op_sw:    begin alu_src = 1'b1; wr_mem = 1'b1; end
      // compare rs with rt for branches
      op_beq:   begin alu_op = alu_sub; branch = 1'b1; end
      op_bne:   begin alu_op = alu_sub; branch = 1'b1; branch_ne = 1'b1; end
      op_j:     jump = 1'b1;
      op_jal:   begin jump = 1'b1; link = 1'b1; wr_reg = 1'b1; end
      default:  ;
    endcase
  end

  assign reg_write  = wr_reg & step;
  assign hi_write   = wr_hi & step;
  assign lo_write   = wr_lo & step;
  assign mult_start = mult & step;
  assign data_read  = rd_mem & step;
  assign data_write = wr_mem & step;

endmodule

// File: execute/alu.sv
`timescale 1ns/1ps

module alu import mips_pkg::*; (
  input  logic [3:0]  alu_op,
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  logic [4:0]  shamt,
  output logic [31:0] result,
  output logic        equal
);

  always_comb begin
    case (alu_op)
      alu_add:
        result = a + b;
      alu_sub:
        result = a - b;
      alu_and:
        result = a & b;
      alu_or:
        result = a | b;
      alu_xor:
        result = a ^ b;
      alu_nor:
        result = ~(a | b);
      // set-on-less-than, zero or one
      alu_slt:
        result = {31'd0, $signed(a) < $signed(b)};
      alu_sltu:
        result = {31'd0, a < b};
      // shifts act on the rt operand
      alu_sll:
        result = b << shamt;
      alu_srl:
        result = b >> shamt;
      alu_sra:
        result = $unsigned($signed(b) >>> shamt);
      // immediate into upper half
      alu_lui:
        result = {b[15:0], 16'h0000};
      default:
        result = 32'h0000_0000;
    endcase
  end

  // beq/bne compare
  assign equal = (a == b);

endmodule

// File: execute/mult_unit.sv
`timescale 1ns/1ps

module mult_unit import mips_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        mult_start,
  input  logic        hi_write,
  input  logic        lo_write,
  input  logic [31:0] a,
  input  logic [31:0] b,
  output logic [31:0] hi,
  output logic [31:0] lo
);

  logic [63:0] product;

  // unsigned only, multu
  assign product = {32'd0, a} * {32'd0, b};

  always_ff @(posedge clk) begin
    if (reset) begin
      hi <= 32'h0000_0000;
      lo <= 32'h0000_0000;
    end else if (mult_start) begin
      hi <= product[63:32];
      lo <= product[31:0];
    end else begin
      // mthi / mtlo each load one half
      if (hi_write)
        hi <= a;
      if (lo_write)
        lo <= a;
    end
  end

endmodule

// File: source/mips_cpu_harvard.sv
`timescale 1ns/1ps

module mips_cpu_harvard import mips_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  output logic        active,
  output logic [31:0] register_v0,

  input  logic        clk_enable,

  output logic [31:0] instr_address,
  input  logic [31:0] instr_readdata,

  output logic [31:0] data_address,
  output logic        data_write,
  output logic        data_read,
  output logic [31:0] data_writedata,
  input  logic [31:0] data_readdata
);

  instr_t      instr;
  logic        step;
  logic [31:0] pc_plus4;
  logic [3:0]  alu_op;
  logic        alu_src, imm_zero, dest_rd, link;
  logic        reg_write, mem_to_reg, hi_to_reg, lo_to_reg;
  logic        hi_write, lo_write, mult_start;
  logic        branch, branch_ne, jump, jump_reg;
  logic [31:0] rs_data, rt_data;
  logic [31:0] imm_ext, alu_b, alu_result;
  logic        equal;
  logic [31:0] hi, lo;
  logic [4:0]  write_addr;
  logic [31:0] write_data;

  assign instr = instr_readdata;

  pc_unit u_pc_unit (
    .clk           (clk),
    .reset         (reset),
    .clk_enable    (clk_enable),
    .instr         (instr),
    .rs_data       (rs_data),
    .branch        (branch),
    .branch_ne     (branch_ne),
    .equal         (equal),
    .jump          (jump),
    .jump_reg      (jump_reg),
    .instr_address (instr_address),
    .pc_plus4      (pc_plus4),
    .active        (active),
    .step          (step)
  );

  control u_control (
    .instr      (instr),
    .step       (step),
    .alu_op     (alu_op),
    .alu_src    (alu_src),
    .imm_zero   (imm_zero),
    .dest_rd    (dest_rd),
    .link       (link),
    .reg_write  (reg_write),
    .mem_to_reg (mem_to_reg),
    .hi_to_reg  (hi_to_reg),
    .lo_to_reg  (lo_to_reg),
    .hi_write   (hi_write),
    .lo_write   (lo_write),
    .mult_start (mult_start),
    .branch     (branch),
    .branch_ne  (branch_ne),
    .jump       (jump),
    .jump_reg   (jump_reg),
    .data_read  (data_read),
    .data_write (data_write)
  );

  // destination: r31 for jal, rd for r-type, rt otherwise
  assign write_addr = link ? 5'd31 : (dest_rd ? instr.r.rd : instr.r.rt);

  always_comb begin
    if (link)
      write_data = pc_plus4;
    else if (mem_to_reg)
      write_data = data_readdata;
    else if (hi_to_reg)
      write_data = hi;
    else if (lo_to_reg)
      write_data = lo;
    else
      write_data = alu_result;
  end

  register_file u_register_file (
    .clk         (clk),
    .reset       (reset),
    .rs_addr     (instr.r.rs),
    .rt_addr     (instr.r.rt),
    .rd_addr     (write_addr),
    .rd_data     (write_data),
    .write       (reg_write),
    .rs_data     (rs_data),
    .rt_data     (rt_data),
    .register_v0 (register_v0)
  );

  // andi/ori/xori/lui take the immediate zero-extended
  assign imm_ext = imm_zero ? {16'h0000, instr.i.imm} : {{16{instr.i.imm[15]}}, instr.i.imm};
  assign alu_b   = alu_src ? imm_ext : rt_data;

  alu u_alu (
    .alu_op (alu_op),
    .a      (rs_data),
    .b      (alu_b),
    .shamt  (instr.r.shamt),
    .result (alu_result),
    .equal  (equal)
  );

  mult_unit u_mult_unit (
    .clk        (clk),
    .reset      (reset),
    .mult_start (mult_start),
    .hi_write   (hi_write),
    .lo_write   (lo_write),
    .a          (rs_data),
    .b          (rt_data),
    .hi         (hi),
    .lo         (lo)
  );

  assign data_address   = alu_result;
  assign data_writedata = rt_data;

endmodule

// File: bench/mips_assert.sv
`timescale 1ns/1ps

module mips_assert (
  input logic        clk,
  input logic        reset,
  input logic        active,
  input logic        clk_enable,
  input logic        data_read,
  input logic        data_write,
  input logic [31:0] instr_address
);

  int failures = 0;

  // one memory strobe per instruction
  strobe_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(data_read && data_write))
    else begin
      $error("data_read and data_write high together");
      failures++;
    end

  // a halted core writes nothing
  no_write_halted: assert property (@(posedge clk) disable iff (reset)
    !active |-> !data_write)
    else begin
      $error("data_write high while inactive");
      failures++;
    end

  stall_holds_pc: assert property (@(posedge clk) disable iff (reset)
    !clk_enable |=> $stable(instr_address))
    else begin
      $error("instr_address moved while clk_enable was low");
      failures++;
    end

endmodule

bind mips_cpu_harvard mips_assert u_assert (
  .clk           (clk),
  .reset         (reset),
  .active        (active),
  .clk_enable    (clk_enable),
  .data_read     (data_read),
  .data_write    (data_write),
  .instr_address (instr_address)
);

// File: bench/mips_tb.sv
`timescale 1ns/1ps

module mips_tb import mips_pkg::*; ();

  // all programs together take under 500 cycles
  localparam int cycle_limit = 4 * 500;

  logic        clk, reset, clk_enable, active, data_write, data_read;
  logic [31:0] register_v0, instr_address, instr_readdata;
  logic [31:0] data_address, data_writedata, data_readdata, fetch_offset;
  logic [31:0] imem [64];
  logic [31:0] dmem [256];
  instr_t      prog [$];
  int          cycles, errors, tests_passed, tests_failed;

  mips_cpu_harvard u_dut (
    .clk            (clk),
    .reset          (reset),
    .active         (active),
    .register_v0    (register_v0),
    .clk_enable     (clk_enable),
    .instr_address  (instr_address),
    .instr_readdata (instr_readdata),
    .data_address   (data_address),
    .data_write     (data_write),
    .data_read      (data_read),
    .data_writedata (data_writedata),
    .data_readdata  (data_readdata)
  );

  always #2 clk = ~clk;

  // instruction words are counted from the reset vector
  assign fetch_offset   = instr_address - reset_vector;
  // outside the program an addiu on r2, which a halted core must not retire
  assign instr_readdata = (fetch_offset < 32'd256) ? imem[fetch_offset[7:2]]
                                                   : {op_addiu, 5'd2, 5'd2, 16'h0001};
  // data memory answers only a read strobe
  assign data_readdata  = data_read ? dmem[data_address[9:2]] : 32'hxxxx_xxxx;

  always @(posedge clk) begin
    if (data_write)
      dmem[data_address[9:2]] <= data_writedata;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout: the core did not halt within %0d cycles", cycle_limit);
      $display("test failed");
      $finish;
    end
  end

  function automatic instr_t rtype(input logic [5:0] funct, input logic [4:0] rs,
                                   input logic [4:0] rt, input logic [4:0] rd,
                                   input logic [4:0] shamt);
    instr_t w;
    w.r = '{op_special, rs, rt, rd, shamt, funct};
    return w;
  endfunction

  function automatic instr_t itype(input logic [5:0] op, input logic [4:0] rs,
                                   input logic [4:0] rt, input logic [15:0] imm);
    instr_t w;
    w.i = '{op, rs, rt, imm};
    return w;
  endfunction

  function automatic instr_t jtype(input logic [5:0] op, input logic [25:0] target);
    instr_t w;
    w.j = '{op, target};
    return w;
  endfunction

  task automatic load_const(input logic [4:0] r, input logic [31:0] value);
    prog.push_back(itype(op_lui, 5'd0, r, value[31:16]));
    prog.push_back(itype(op_ori, r, r, value[15:0]));
  endtask

  // unused words read as nop, data words get an address-based pattern
  task automatic load_program();
    for (int n = 0; n < 64; n++)
      imem[n] = (n < prog.size()) ? prog[n] : 32'h0000_0000;
    for (int n = 0; n < 256; n++)
      dmem[n] = (32'(n) << 2) * 32'h9e37_79b9 ^ 32'hc3c3_c3c3;
    prog.delete();
  endtask

  task automatic pulse_reset();
    @(posedge clk);
    #1 reset = 1'b1;
    repeat (5) @(posedge clk);
    #1 reset = 1'b0;
  endtask

  task automatic run_to_halt();
    while (active) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      $display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("error at %0t: %s expected %b, got %b", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      tests_passed++;
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic check_reset_state();
    int e0;
    e0 = errors;
    // a store sits at the reset vector, so the strobe must be held off by reset
    prog.push_back(itype(op_sw, 5'd0, 5'd0, 16'h0010));
    prog.push_back(rtype(fn_jr, 5'd0, 5'd0, 5'd0, 5'd0));
    load_program();
    @(posedge clk);
    #1 reset = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    check_bit("data_write", data_write, 1'b0);
    reset = 1'b0;
    check_bit("active", active, 1'b1);
    check_word("instr_address", instr_address, reset_vector);
    run_to_halt();
    finish_test("reset state", e0);
  endtask

  task automatic run_alu_program();
    logic [15:0] imm;
    logic [31:0] a, b, s, d, x, v;
    int e0;
    e0 = errors;
    imm = 16'($urandom);
    b = $urandom;
    a = {{16{imm[15]}}, imm};
    prog.push_back(itype(op_addiu, 5'd0, 5'd8, imm));
    load_const(5'd9, b);
    prog.push_back(rtype(fn_addu, 5'd8, 5'd9, 5'd10, 5'd0));
    prog.push_back(rtype(fn_subu, 5'd9, 5'd8, 5'd11, 5'd0));
    prog.push_back(rtype(fn_and, 5'd10, 5'd11, 5'd12, 5'd0));
    prog.push_back(rtype(fn_or, 5'd10, 5'd11, 5'd13, 5'd0));
    prog.push_back(rtype(fn_xor, 5'd12, 5'd13, 5'd14, 5'd0));
    prog.push_back(rtype(fn_slt, 5'd8, 5'd9, 5'd15, 5'd0));
    prog.push_back(rtype(fn_sltu, 5'd8, 5'd9, 5'd16, 5'd0));
    prog.push_back(rtype(fn_sll, 5'd0, 5'd14, 5'd17, 5'd4));
    prog.push_back(rtype(fn_srl, 5'd0, 5'd8, 5'd18, 5'd3));
    prog.push_back(rtype(fn_sra, 5'd0, 5'd8, 5'd19, 5'd2));
    prog.push_back(rtype(fn_addu, 5'd17, 5'd18, 5'd2, 5'd0));
    prog.push_back(rtype(fn_xor, 5'd2, 5'd19, 5'd2, 5'd0));
    prog.push_back(rtype(fn_addu, 5'd2, 5'd15, 5'd2, 5'd0));
    prog.push_back(rtype(fn_addu, 5'd2, 5'd16, 5'd2, 5'd0));
    prog.push_back(rtype(fn_jr, 5'd0, 5'd0, 5'd0, 5'd0));
    // reference result
    s = a + b;
    d = b - a;
    x = (s & d) ^ (s | d);
    v = ((x << 4) + (a >> 3)) ^ 32'($signed(a) >>> 2);
    v = v + (($signed(a) < $signed(b)) ? 32'd1 : 32'd0) + ((a < b) ? 32'd1 : 32'd0);
    load_program();
    pulse_reset();
    run_to_halt();
    check_word("register_v0", register_v0, v);
    finish_test("arithmetic and logic", e0);
  endtask

  task automatic run_memory_program();
    logic [31:0] v1, v2;
    int e0;
    e0 = errors;
    v1 = $urandom;
    v2 = $urandom;
    prog.push_back(itype(op_addiu, 5'd0, 5'd8, 16'h0040));
    load_const(5'd9, v1);
    load_const(5'd10, v2);
    prog.push_back(itype(op_sw, 5'd8, 5'd9, 16'h0000));
    prog.push_back(itype(op_sw, 5'd8, 5'd10, 16'h0008));
    prog.push_back(itype(op_lw, 5'd8, 5'd11, 16'h0000));
    prog.push_back(itype(op_lw, 5'd8, 5'd12, 16'h0008));
    prog.push_back(rtype(fn_addu, 5'd11, 5'd12, 5'd2, 5'd0));
    prog.push_back(rtype(fn_jr, 5'd0, 5'd0, 5'd0, 5'd0));
    load_program();
    pulse_reset();
    run_to_halt();
    check_word("dmem[0x40]", dmem[16], v1);
    check_word("dmem[0x48]", dmem[18], v2);
    check_word("register_v0", register_v0, v1 + v2);
    finish_test("memory", e0);
  endtask

  task automatic run_branch_program();
    logic [31:0] n, sub_addr;
    int e0;
    e0 = errors;
    n = 32'd2 + ($urandom % 8);
    sub_addr = reset_vector + 32'd44;
    prog.push_back(itype(op_addiu, 5'd0, 5'd8, n[15:0]));
    prog.push_back(itype(op_addiu, 5'd0, 5'd2, 16'h0000));
    prog.push_back(itype(op_addiu, 5'd2, 5'd2, 16'h0001));
    // back to the increment until r2 reaches n
    prog.push_back(itype(op_bne, 5'd2, 5'd8, 16'hfffe));
    prog.push_back(itype(op_beq, 5'd2, 5'd8, 16'h0001));
    prog.push_back(itype(op_addiu, 5'd2, 5'd2, 16'd100));
    prog.push_back(itype(op_beq, 5'd2, 5'd0, 16'h0001));
    prog.push_back(itype(op_addiu, 5'd2, 5'd2, 16'd10));
    prog.push_back(jtype(op_jal, sub_addr[27:2]));
    prog.push_back(rtype(fn_jr, 5'd0, 5'd0, 5'd0, 5'd0));
    prog.push_back(itype(op_addiu, 5'd2, 5'd2, 16'd1000));
    // subroutine at word 11
    prog.push_back(itype(op_addiu, 5'd2, 5'd2, 16'd7));
    prog.push_back(itype(op_sw, 5'd0, 5'd31, 16'h0080));
    prog.push_back(rtype(fn_jr, 5'd31, 5'd0, 5'd0, 5'd0));
    load_program();
    pulse_reset();
    run_to_halt();
    // loop gives n, taken beq skips 100, untaken beq keeps 10, subroutine adds 7
    check_word("register_v0", register_v0, n + 32'd17);
    check_word("link r31", dmem[32], reset_vector + 32'd32 + 32'd4);
    finish_test("control flow", e0);
  endtask

  task automatic run_multiply_program();
    logic [31:0] x, y;
    logic [63:0] prod;
    int e0;
    e0 = errors;
    x = $urandom;
    y = $urandom;
    prod = 64'(x) * 64'(y);
    load_const(5'd8, x);
    load_const(5'd9, y);
    prog.push_back(rtype(fn_multu, 5'd8, 5'd9, 5'd0, 5'd0));
    prog.push_back(rtype(fn_mflo, 5'd0, 5'd0, 5'd2, 5'd0));
    prog.push_back(rtype(fn_mfhi, 5'd0, 5'd0, 5'd10, 5'd0));
    prog.push_back(itype(op_sw, 5'd0, 5'd10, 16'h0020));
    prog.push_back(rtype(fn_jr, 5'd0, 5'd0, 5'd0, 5'd0));
    load_program();
    pulse_reset();
    run_to_halt();
    check_word("register_v0", register_v0, prod[31:0]);
    check_word("dmem[0x20]", dmem[8], prod[63:32]);
    // mthi and mtlo round trip
    x = $urandom;
    y = $urandom;
    load_const(5'd8, x);
    load_const(5'd9, y);
    prog.push_back(rtype(fn_mthi, 5'd8, 5'd0, 5'd0, 5'd0));
    prog.push_back(rtype(fn_mtlo, 5'd9, 5'd0, 5'd0, 5'd0));
    prog.push_back(rtype(fn_mfhi, 5'd0, 5'd0, 5'd10, 5'd0));
    prog.push_back(rtype(fn_mflo, 5'd0, 5'd0, 5'd2, 5'd0));
    prog.push_back(itype(op_sw, 5'd0, 5'd10, 16'h0024));
    prog.push_back(rtype(fn_jr, 5'd0, 5'd0, 5'd0, 5'd0));
    load_program();
    pulse_reset();
    run_to_halt();
    check_word("register_v0", register_v0, y);
    check_word("dmem[0x24]", dmem[9], x);
    finish_test("multiply", e0);
  endtask

  task automatic run_stall_program();
    logic [31:0] v1, held, fill;
    int e0;
    e0 = errors;
    v1 = $urandom;
    load_const(5'd8, v1);
    prog.push_back(itype(op_addiu, 5'd0, 5'd2, 16'h0077));
    prog.push_back(itype(op_sw, 5'd0, 5'd8, 16'h0030));
    prog.push_back(rtype(fn_jr, 5'd0, 5'd0, 5'd0, 5'd0));
    load_program();
    pulse_reset();
    // stop with the sw about to execute
    while (instr_address != reset_vector + 32'd12) begin
      @(posedge clk);
      #1;
    end
    fill = dmem[12];
    held = instr_address;
    clk_enable = 1'b0;
    repeat (4) begin
      @(posedge clk);
      #1;
      check_word("instr_address", instr_address, held);
      check_bit("data_write", data_write, 1'b0);
    end
    check_word("dmem[0x30]", dmem[12], fill);
    clk_enable = 1'b1;
    run_to_halt();
    check_bit("active", active, 1'b0);
    check_word("dmem[0x30]", dmem[12], v1);
    repeat (10) begin
      @(posedge clk);
      #1;
      check_bit("active", active, 1'b0);
      check_word("instr_address", instr_address, 32'h0000_0000);
      check_word("register_v0", register_v0, 32'h0000_0077);
    end
    finish_test("stall and halt", e0);
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    clk_enable = 1'b1;
    cycles = 0;
    errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    void'($urandom(13));
    check_reset_state();
    run_alu_program();
    run_memory_program();
    run_branch_program();
    run_multiply_program();
    run_stall_program();
    $display("tests: %0d passed, %0d failed, %0d assertion failures",
             tests_passed, tests_failed, u_dut.u_assert.failures);
    if (tests_failed == 0 && u_dut.u_assert.failures == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

// File: verilog.f
common/mips_pkg.sv
source/register_file.sv
source/pc_unit.sv
source/control.sv
execute/alu.sv
execute/mult_unit.sv
source/mips_cpu_harvard.sv
bench/mips_assert.sv
bench/mips_tb.sv
